// ==== source/mmu_defs.svh ====
// mmu sizing macros shared by the TLB, the channels and the testbench
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// translation channels
`define MMU_INST_CHANNELS 2
`define MMU_DATA_CHANNELS 1

// entry array size, index width is log2 of the count
`define MMU_TLB_ENTRIES 32
`define MMU_TLB_INDEX_W 5

// address space identifier
`define MMU_ASID_W 8

// 4 KiB pages only
`define MMU_PFN_W 20
`define MMU_VPN2_W 19

`endif

// ==== source/mmu_pkg.sv ====
// mmu types: addresses, TLB entries, lookup results and exception codes
`include "mmu_defs.svh"

package mmu_pkg;

    typedef logic [31:0] uint32_t;
    typedef logic [31:0] virt_t;
    typedef logic [31:0] phys_t;

    typedef logic [`MMU_TLB_INDEX_W-1:0] tlb_index_t;
    typedef logic [`MMU_ASID_W-1:0] asid_t;

    // one half of a page pair
    typedef struct packed {
        logic [`MMU_PFN_W-1:0] pfn;
        logic cached;
        logic dirty;
        logic valid;
    } page_t;

    // even page maps vaddr bit 12 clear, odd page bit 12 set
    typedef struct packed {
        logic [`MMU_VPN2_W-1:0] vpn2;
        asid_t asid;
        logic global;
        page_t even_page;
        page_t odd_page;
    } tlb_entry_t;

    typedef struct packed {
        logic miss;
        tlb_index_t index;
        page_t page;
    } tlb_resp_t;

    // field layout of cp0 EntryHi
    typedef struct packed {
        logic [`MMU_VPN2_W-1:0] vpn2;
        logic [4:0] zero;
        asid_t asid;
    } entry_hi_t;

    // same word seen raw or by field
    typedef union packed {
        uint32_t raw;
        entry_hi_t f;
    } entry_hi_u;

    typedef enum logic [1:0] {
        EXC_NONE     = 2'd0,
        EXC_REFILL   = 2'd1,
        EXC_INVALID  = 2'd2,
        EXC_MODIFIED = 2'd3
    } exc_t;

endpackage

// ==== source/tlb_lookup.sv ====
// tlb lookup: associative match of one virtual address against all entries
`timescale 1ns/1ps
`include "mmu_defs.svh"

module tlb_lookup #(
    parameter int N_TLB_ENTRIES = `MMU_TLB_ENTRIES
) (
    input  mmu_pkg::tlb_entry_t [N_TLB_ENTRIES-1:0] entries,
    input  mmu_pkg::virt_t                           vaddr,
    input  mmu_pkg::asid_t                           asid,
    output mmu_pkg::tlb_resp_t                       resp
);

    import mmu_pkg::*;

    logic [N_TLB_ENTRIES-1:0] match;
    logic                     hit;
    tlb_index_t               hit_idx;
    tlb_entry_t               hit_entry;

    // vpn2 compare, asid ignored for global entries
    for (genvar i = 0; i < N_TLB_ENTRIES; i++) begin : gen_match
        assign match[i] = (entries[i].vpn2 == vaddr[31:13]) &&
                          ((entries[i].asid == asid) || entries[i].global);
    end

    // lowest matching index wins
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = N_TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit     = 1'b1;
                hit_idx = tlb_index_t'(i);
            end
        end
    end

    assign hit_entry = entries[hit_idx];

    // bit 12 picks the half of the pair
    always_comb begin
        resp.miss  = ~hit;
        resp.index = hit_idx;
        resp.page  = '0;
        if (hit) begin
            if (vaddr[12]) begin
                resp.page = hit_entry.odd_page;
            end else begin
                resp.page = hit_entry.even_page;
            end
        end
    end

endmodule

// ==== source/tlb.sv ====
// tlb: entry store with cp0 read/write, per-channel lookup ports and probe
`timescale 1ns/1ps
`include "mmu_defs.svh"

module tlb #(
    parameter int N_INST_CHANNEL = `MMU_INST_CHANNELS,
    parameter int N_ISSUE        = `MMU_DATA_CHANNELS,
    parameter int N_TLB_ENTRIES  = `MMU_TLB_ENTRIES
) (
    input  logic                                     clk,
    input  logic                                     rst,
    // current address space
    input  mmu_pkg::asid_t                           asid,
    // fetch lookups
    input  mmu_pkg::virt_t     [N_INST_CHANNEL-1:0]  inst_vaddr,
    output mmu_pkg::tlb_resp_t [N_INST_CHANNEL-1:0]  inst_resp,
    // data lookups
    input  mmu_pkg::virt_t     [N_ISSUE-1:0]         data_vaddr,
    output mmu_pkg::tlb_resp_t [N_ISSUE-1:0]         data_resp,
    // TLBR / TLBWI / TLBWR
    input  mmu_pkg::tlb_index_t                      tlbrw_index,
    input  logic                                     tlbrw_we,
    input  mmu_pkg::tlb_entry_t                      tlbrw_wrdata,
    output mmu_pkg::tlb_entry_t                      tlbrw_rddata,
    // TLBP
    input  mmu_pkg::entry_hi_u                       tlbp_entry_hi,
    output mmu_pkg::uint32_t                         tlbp_index
);

    import mmu_pkg::*;

    tlb_entry_t [N_TLB_ENTRIES-1:0] entries;
    tlb_resp_t                      tlbp_resp;

    // one entry written per cycle, visible from the next cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            entries <= '0;
        end else if (tlbrw_we) begin
            entries[tlbrw_index] <= tlbrw_wrdata;
        end
    end

    assign tlbrw_rddata = entries[tlbrw_index];

    for (genvar i = 0; i < N_INST_CHANNEL; i++) begin : gen_inst_lookup
        tlb_lookup #(
            .N_TLB_ENTRIES(N_TLB_ENTRIES)
        ) inst_lookup_i (
            .entries(entries),
            .vaddr  (inst_vaddr[i]),
            .asid   (asid),
            .resp   (inst_resp[i])
        );
    end

    for (genvar i = 0; i < N_ISSUE; i++) begin : gen_data_lookup
        tlb_lookup #(
            .N_TLB_ENTRIES(N_TLB_ENTRIES)
        ) data_lookup_i (
            .entries(entries),
            .vaddr  (data_vaddr[i]),
            .asid   (asid),
            .resp   (data_resp[i])
        );
    end

    // probe uses the EntryHi asid, not the current one
    tlb_lookup #(
        .N_TLB_ENTRIES(N_TLB_ENTRIES)
    ) tlbp_lookup_i (
        .entries(entries),
        .vaddr  (tlbp_entry_hi.raw),
        .asid   (tlbp_entry_hi.f.asid),
        .resp   (tlbp_resp)
    );

    // miss flag in bit 31, index in the low bits
    assign tlbp_index = {
        tlbp_resp.miss,
        {(32 - `MMU_TLB_INDEX_W - 1){1'b0}},
        tlbp_resp.index
    };

endmodule

// ==== source/addr_translate.sv ====
// address translation for one channel: segment decode and exception classification
`timescale 1ns/1ps

module addr_translate (
    input  mmu_pkg::virt_t     vaddr,
    input  logic               is_store,
    input  mmu_pkg::tlb_resp_t resp,
    output mmu_pkg::phys_t     paddr,
    output logic               cached,
    output mmu_pkg::exc_t      exc
);

    import mmu_pkg::*;

    logic unmapped;
    logic kseg0;

    // kseg0 is 100, kseg1 is 101
    assign unmapped = (vaddr[31:30] == 2'b10);
    assign kseg0    = (vaddr[31:29] == 3'b100);

    always_comb begin
        paddr  = '0;
        cached = 1'b0;
        exc    = EXC_NONE;
        if (unmapped) begin
            paddr  = {3'b000, vaddr[28:0]};
            cached = kseg0;
        end else if (resp.miss) begin
            exc = EXC_REFILL;
        end else if (!resp.page.valid) begin
            exc = EXC_INVALID;
        end else if (is_store && !resp.page.dirty) begin
            // write to a clean page
            exc = EXC_MODIFIED;
        end else begin
            paddr  = {resp.page.pfn, vaddr[11:0]};
            cached = resp.page.cached;
        end
    end

endmodule

// ==== source/mmu_top.sv ====
// mmu top: shared TLB feeding two fetch channels and one data channel
`timescale 1ns/1ps
`include "mmu_defs.svh"

module mmu_top (
    input  logic                                           clk,
    input  logic                                           rst,
    input  mmu_pkg::asid_t                                 asid,
    // instruction fetch
    input  mmu_pkg::virt_t  [`MMU_INST_CHANNELS-1:0]       inst_vaddr,
    output mmu_pkg::phys_t  [`MMU_INST_CHANNELS-1:0]       inst_paddr,
    output logic            [`MMU_INST_CHANNELS-1:0]       inst_cached,
    output mmu_pkg::exc_t   [`MMU_INST_CHANNELS-1:0]       inst_exc,
    // data access
    input  mmu_pkg::virt_t                                 data_vaddr,
    input  logic                                           data_store,
    output mmu_pkg::phys_t                                 data_paddr,
    output logic                                           data_cached,
    output mmu_pkg::exc_t                                  data_exc,
    // cp0 side
    input  mmu_pkg::tlb_index_t                            tlbrw_index,
    input  logic                                           tlbrw_we,
    input  mmu_pkg::tlb_entry_t                            tlbrw_wrdata,
    output mmu_pkg::tlb_entry_t                            tlbrw_rddata,
    input  mmu_pkg::entry_hi_u                             tlbp_entry_hi,
    output mmu_pkg::uint32_t                               tlbp_index
);

    import mmu_pkg::*;

    tlb_resp_t [`MMU_INST_CHANNELS-1:0] inst_resp;
    tlb_resp_t [`MMU_DATA_CHANNELS-1:0] data_resp;

    tlb #(
        .N_INST_CHANNEL(`MMU_INST_CHANNELS),
        .N_ISSUE       (`MMU_DATA_CHANNELS),
        .N_TLB_ENTRIES (`MMU_TLB_ENTRIES)
    ) tlb_i (
        .clk          (clk),
        .rst          (rst),
        .asid         (asid),
        .inst_vaddr   (inst_vaddr),
        .inst_resp    (inst_resp),
        .data_vaddr   (data_vaddr),
        .data_resp    (data_resp),
        .tlbrw_index  (tlbrw_index),
        .tlbrw_we     (tlbrw_we),
        .tlbrw_wrdata (tlbrw_wrdata),
        .tlbrw_rddata (tlbrw_rddata),
        .tlbp_entry_hi(tlbp_entry_hi),
        .tlbp_index   (tlbp_index)
    );

    // fetches never write
    for (genvar i = 0; i < `MMU_INST_CHANNELS; i++) begin : gen_inst_xlate
        addr_translate inst_xlate_i (
            .vaddr   (inst_vaddr[i]),
            .is_store(1'b0),
            .resp    (inst_resp[i]),
            .paddr   (inst_paddr[i]),
            .cached  (inst_cached[i]),
            .exc     (inst_exc[i])
        );
    end

    addr_translate data_xlate_i (
        .vaddr   (data_vaddr),
        .is_store(data_store),
        .resp    (data_resp[0]),
        .paddr   (data_paddr),
        .cached  (data_cached),
        .exc     (data_exc)
    );

endmodule

// ==== sim/tb_clock.sv ====
// testbench clock source, free running from time zero
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// ==== sim/mmu_checker.sv ====
// tlb checker: concurrent assertions on the cp0 read/write and probe ports
`timescale 1ns/1ps
`include "mmu_defs.svh"

module mmu_checker (
    input logic                                       clk,
    input logic                                       rst,
    input mmu_pkg::tlb_entry_t [`MMU_TLB_ENTRIES-1:0] entries,
    input mmu_pkg::tlb_index_t                        tlbrw_index,
    input logic                                       tlbrw_we,
    input mmu_pkg::tlb_entry_t                        tlbrw_wrdata,
    input mmu_pkg::tlb_entry_t                        tlbrw_rddata,
    input mmu_pkg::entry_hi_u                         tlbp_entry_hi,
    input mmu_pkg::uint32_t                           tlbp_index
);

    logic probe_hit;

    // some entry holds the probed vpn2 under the EntryHi asid or as global
    always_comb begin
        probe_hit = 1'b0;
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
            if (entries[i].vpn2 == tlbp_entry_hi.f.vpn2 &&
                (entries[i].global || entries[i].asid == tlbp_entry_hi.f.asid)) begin
                probe_hit = 1'b1;
            end
        end
    end

    // written entry visible on the read port one cycle later
    write_read_back: assert property (@(posedge clk) disable iff (rst)
        tlbrw_we |=> (tlbrw_index != $past(tlbrw_index)) ||
                     (tlbrw_rddata == $past(tlbrw_wrdata)))
        else $error("read port does not return the entry written the cycle before");

    probe_pad_zero: assert property (@(posedge clk) disable iff (rst)
        tlbp_index[30:`MMU_TLB_INDEX_W] == '0)
        else $error("probe result has bits set between miss flag and index");

    probe_miss_flag: assert property (@(posedge clk) disable iff (rst)
        probe_hit |-> !tlbp_index[31])
        else $error("probe miss flag set although an entry matches the probed EntryHi");

endmodule

bind tlb mmu_checker tlb_checker_i (
    .clk          (clk),
    .rst          (rst),
    .entries      (entries),
    .tlbrw_index  (tlbrw_index),
    .tlbrw_we     (tlbrw_we),
    .tlbrw_wrdata (tlbrw_wrdata),
    .tlbrw_rddata (tlbrw_rddata),
    .tlbp_entry_hi(tlbp_entry_hi),
    .tlbp_index   (tlbp_index)
);

// ==== sim/mmu_tb.sv ====
// mmu testbench: directed translation, TLB read/write and probe tests
`timescale 1ns/1ps
`include "mmu_defs.svh"

module mmu_tb;

    import mmu_pkg::*;

    localparam int CLK_PERIOD = 40;
    // reset, then per test: one cycle per access or probe, two per write
    localparam int TEST_CYCLES = 5 + 3 + 2 + 12 + 6 + 3 + 6;
    localparam int MARGIN_CYCLES = 40;
    localparam virt_t VA_USER = 32'h0040_0000;
    localparam virt_t VA_GLOBAL = 32'h7f00_0000;
    localparam virt_t VA_STORE = 32'h1000_0000;

    logic                                 clk;
    logic                                 rst;
    asid_t                                asid;
    virt_t      [`MMU_INST_CHANNELS-1:0]  inst_vaddr;
    phys_t      [`MMU_INST_CHANNELS-1:0]  inst_paddr;
    logic       [`MMU_INST_CHANNELS-1:0]  inst_cached;
    exc_t       [`MMU_INST_CHANNELS-1:0]  inst_exc;
    virt_t                                data_vaddr;
    logic                                 data_store;
    phys_t                                data_paddr;
    logic                                 data_cached;
    exc_t                                 data_exc;
    tlb_index_t                           tlbrw_index;
    logic                                 tlbrw_we;
    tlb_entry_t                           tlbrw_wrdata;
    tlb_entry_t                           tlbrw_rddata;
    entry_hi_u                            tlbp_entry_hi;
    uint32_t                              tlbp_index;

    // expected contents of the entry array
    tlb_entry_t ref_entries [`MMU_TLB_ENTRIES];
    int errors = 0;

    tb_clock #(.PERIOD_NS(CLK_PERIOD)) clock_i (.clk(clk));

    mmu_top mmu_top_i (.*);

    task automatic stop_on_error();
        errors++;
        $display("Verification failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_phys(input string name, input phys_t got, input phys_t exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_exc(input string name, input exc_t got, input exc_t exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_entry(input string name, input tlb_entry_t got, input tlb_entry_t exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_word(input string name, input uint32_t got, input uint32_t exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    // first entry that matches on vpn2 and on asid or global
    task automatic ref_match(input logic [`MMU_VPN2_W-1:0] vpn2, input asid_t a,
                             output logic found, output int idx);
        found = 1'b0;
        idx = 0;
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
            if (!found && ref_entries[i].vpn2 == vpn2 &&
                (ref_entries[i].global || ref_entries[i].asid == a)) begin
                found = 1'b1;
                idx = i;
            end
        end
    endtask

    task automatic check_channel(input string ch, input virt_t va, input asid_t a,
                                 input logic store, input phys_t pa, input logic c,
                                 input exc_t x);
        logic  found;
        int    idx;
        page_t pg;
        exc_t  exp_x;
        phys_t exp_pa;
        logic  exp_c;
        ref_match(va[31:13], a, found, idx);
        pg = va[12] ? ref_entries[idx].odd_page : ref_entries[idx].even_page;
        exp_x = EXC_NONE;
        exp_pa = {pg.pfn, va[11:0]};
        exp_c = pg.cached;
        if (va[31:29] inside {3'b100, 3'b101}) begin
            exp_pa = va & 32'h1fff_ffff;
            exp_c = (va[31:29] == 3'b100);
        end else if (!found) begin
            exp_x = EXC_REFILL;
        end else if (!pg.valid) begin
            exp_x = EXC_INVALID;
        end else if (store && !pg.dirty) begin
            exp_x = EXC_MODIFIED;
        end
        check_exc({ch, "_exc"}, x, exp_x);
        // address and cached flag only mean something without an exception
        if (exp_x == EXC_NONE) begin
            check_phys({ch, "_paddr"}, pa, exp_pa);
            check_flag({ch, "_cached"}, c, exp_c);
        end
    endtask

    task automatic run_access(input asid_t a, input virt_t iv0, input virt_t iv1,
                              input virt_t dv, input logic store);
        @(posedge clk);
        asid <= a;
        inst_vaddr[0] <= iv0;
        inst_vaddr[1] <= iv1;
        data_vaddr <= dv;
        data_store <= store;
        @(negedge clk);
        check_channel("inst_0", iv0, a, 1'b0, inst_paddr[0], inst_cached[0], inst_exc[0]);
        check_channel("inst_1", iv1, a, 1'b0, inst_paddr[1], inst_cached[1], inst_exc[1]);
        check_channel("data", dv, a, store, data_paddr, data_cached, data_exc);
    endtask

    task automatic write_entry(input int idx, input tlb_entry_t e);
        @(posedge clk);
        tlbrw_index <= tlb_index_t'(idx);
        tlbrw_wrdata <= e;
        tlbrw_we <= 1'b1;
        @(posedge clk);
        tlbrw_we <= 1'b0;
        ref_entries[idx] = e;
    endtask

    task automatic check_read(input int idx);
        @(posedge clk);
        tlbrw_index <= tlb_index_t'(idx);
        @(negedge clk);
        check_entry("tlbrw_rddata", tlbrw_rddata, ref_entries[idx]);
    endtask

    task automatic run_probe(input logic [`MMU_VPN2_W-1:0] vpn2, input asid_t a);
        entry_hi_u eh;
        logic      found;
        int        idx;
        eh.f.vpn2 = vpn2;
        eh.f.zero = '0;
        eh.f.asid = a;
        ref_match(vpn2, a, found, idx);
        @(posedge clk);
        tlbp_entry_hi <= eh;
        @(negedge clk);
        check_word("tlbp_index", tlbp_index, found ? uint32_t'(idx) : 32'h8000_0000);
    endtask

    // flags are {cached, dirty, valid}
    function automatic page_t make_page(input logic [2:0] flags);
        return {20'($urandom), flags};
    endfunction

    function automatic tlb_entry_t make_entry(input virt_t va, input asid_t a, input logic g,
                                              input page_t even, input page_t odd);
        return {va[31:13], a, g, even, odd};
    endfunction

    function automatic virt_t rand_offset();
        return virt_t'($urandom_range(4095));
    endfunction

    task automatic test_reset_state();
        run_access(8'h00, 32'h0000_0000, VA_USER, 32'hc000_0000, 1'b0);
        run_access(8'h05, 32'h0000_0000, 32'h7fff_f000, 32'h0000_0004, 1'b1);
        run_probe(19'h00100, 8'h00);
    endtask

    task automatic test_unmapped();
        run_access(8'h07, 32'h8000_1234, 32'ha000_5678, 32'h9fff_fffc, 1'b0);
        run_access(8'h07, 32'hbfc0_0000, 32'h8123_4560, 32'ha000_0010, 1'b1);
    endtask

    task automatic test_read_write();
        int         idxs[4] = '{1, 2, 17, 31};
        logic [95:0] r;
        foreach (idxs[i]) begin
            r = {$urandom, $urandom, $urandom};
            write_entry(idxs[i], r[73:0]);
        end
        foreach (idxs[i]) begin
            check_read(idxs[i]);
        end
    endtask

    task automatic test_mapped_hits();
        write_entry(5, make_entry(VA_USER, 8'h12, 1'b0, make_page(3'b111), make_page(3'b011)));
        write_entry(6, make_entry(VA_GLOBAL, 8'h33, 1'b1, make_page(3'b101), make_page(3'b111)));
        run_access(8'h12, VA_USER | rand_offset(), VA_USER | 32'h1000 | rand_offset(),
                   VA_GLOBAL | 32'h1000 | rand_offset(), 1'b0);
        // other asid: global entry still hits, user entry misses
        run_access(8'h44, VA_USER | rand_offset(), VA_GLOBAL | rand_offset(),
                   VA_USER | 32'h1000 | rand_offset(), 1'b1);
    endtask

    task automatic test_probe();
        run_probe(VA_USER[31:13], 8'h12);
        run_probe(VA_GLOBAL[31:13], 8'h99);
        run_probe(19'h12345, 8'h12);
    endtask

    task automatic test_store_perm();
        write_entry(9, make_entry(VA_STORE, 8'h21, 1'b0, make_page(3'b101), make_page(3'b011)));
        write_entry(10, make_entry(VA_STORE | 32'h2000, 8'h21, 1'b0, make_page(3'b110),
                                   make_page(3'b111)));
        run_access(8'h21, VA_STORE | rand_offset(), VA_STORE | 32'h2000 | rand_offset(),
                   VA_STORE | rand_offset(), 1'b1);
        run_access(8'h21, VA_STORE | 32'h1000 | rand_offset(), VA_STORE | rand_offset(),
                   VA_STORE | 32'h1000 | rand_offset(), 1'b1);
    endtask

    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles",
                 TEST_CYCLES + MARGIN_CYCLES);
        stop_on_error();
    end

    initial begin
        void'($urandom(16187));
        rst = 1'b1;
        asid = '0;
        inst_vaddr = '0;
        data_vaddr = '0;
        data_store = 1'b0;
        tlbrw_index = '0;
        tlbrw_we = 1'b0;
        tlbrw_wrdata = '0;
        tlbp_entry_hi = '0;
        foreach (ref_entries[i]) begin
            ref_entries[i] = '0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        test_reset_state();
        test_unmapped();
        test_read_write();
        test_mapped_hits();
        test_probe();
        test_store_perm();
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== mmu.f ====
+incdir+source
source/mmu_pkg.sv
source/tlb_lookup.sv
source/tlb.sv
source/addr_translate.sv
source/mmu_top.sv
sim/tb_clock.sv
sim/mmu_checker.sv
sim/mmu_tb.sv

// ==== Bender.yml ====
package:
  name: mmu

sources:
  - include_dirs:
      - source
    files:
      - source/mmu_pkg.sv
      - source/tlb_lookup.sv
      - source/tlb.sv
      - source/addr_translate.sv
      - source/mmu_top.sv

  - target: simulation
    include_dirs:
      - source
    files:
      - sim/tb_clock.sv
      - sim/mmu_checker.sv
      - sim/mmu_tb.sv
